// ==== Makefile ====
# Verilator build and run for the APB peripheral subsystem testbench

TOP = tb_periph_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "Simulation finished: PASS" run.log

clean:
	rm -rf obj_dir run.log

// ==== apb_if.sv ====
// ----------------------------------------------------------------------
// APB interface
// One requester and one completer, no wait-state limit
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface apb_if;
	import periph_pkg::*;

	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;

	modport master (
		output psel, penable, pwrite, paddr, pwdata,
		input  prdata, pready, pslverr
	);

	modport slave (
		input  psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

`default_nettype wire

// ==== apb_splitter.sv ====
// ----------------------------------------------------------------------
// APB address splitter
// Routes a host transfer to the timer or the UART window by the top
// address bits, strips the window bits from the address and returns
// the selected completer's response. Unmapped addresses get an error
// response from the splitter itself.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module apb_splitter #(
	parameter periph_pkg::apb_addr_t TIMER_BASE = periph_pkg::DEFAULT_TIMER_BASE,
	parameter periph_pkg::apb_addr_t UART_BASE  = periph_pkg::DEFAULT_UART_BASE
) (
	apb_if.slave  host,
	apb_if.master timer,
	apb_if.master uart
);
	import periph_pkg::*;

	logic      hit_timer;
	logic      hit_uart;
	apb_addr_t offset;

	// ------------------------------------------------------------------
	// Decode

	assign hit_timer = (host.paddr & WINDOW_MASK) == TIMER_BASE;
	assign hit_uart  = (host.paddr & WINDOW_MASK) == UART_BASE;
	assign offset    = host.paddr & ~WINDOW_MASK;

	// Select and enable only go to the addressed window
	assign timer.psel    = host.psel && hit_timer;
	assign timer.penable = host.penable && hit_timer;
	assign timer.pwrite  = host.pwrite;
	assign timer.paddr   = offset;
	assign timer.pwdata  = host.pwdata;

	assign uart.psel    = host.psel && hit_uart;
	assign uart.penable = host.penable && hit_uart;
	assign uart.pwrite  = host.pwrite;
	assign uart.paddr   = offset;
	assign uart.pwdata  = host.pwdata;

	// ------------------------------------------------------------------
	// Response return

	always_comb begin
		if (hit_timer) begin
			host.prdata  = timer.prdata;
			host.pready  = timer.pready;
			host.pslverr = timer.pslverr;
		end else if (hit_uart) begin
			host.prdata  = uart.prdata;
			host.pready  = uart.pready;
			host.pslverr = uart.pslverr;
		end else begin
			// Unmapped window answers at once with an error
			host.prdata  = '0;
			host.pready  = 1'b1;
			host.pslverr = host.psel;
		end
	end

	// A bad pair of base parameters would overlap the windows
	always_comb begin
		assert (!(timer.psel && uart.psel))
			else $error("apb_splitter: timer and UART selected together");
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
periph_pkg.sv
apb_if.sv
apb_splitter.sv
riscv_timer.sv
uart_tx_mini.sv
periph_subsystem.sv
tb_periph_subsystem.sv

// ==== periph_pkg.sv ====
// ----------------------------------------------------------------------
// Peripheral subsystem package
// Bus and register types, register offsets, the default address map
// and the UART transmit engine states
// ----------------------------------------------------------------------

`default_nettype none

package periph_pkg;

	// Bus and register types
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [63:0] mtime_t;
	typedef logic [15:0] uart_div_t;
	typedef logic [7:0]  uart_byte_t;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

	// Address map, 16 kB windows selected by the top two bits
	localparam apb_addr_t DEFAULT_TIMER_BASE = 16'h0000;
	localparam apb_addr_t DEFAULT_UART_BASE  = 16'h4000;
	localparam apb_addr_t WINDOW_MASK        = 16'hc000;

	// Timer registers
	localparam apb_addr_t TIMER_CTRL_OFS      = 16'h0000;
	localparam apb_addr_t TIMER_MTIME_OFS     = 16'h0008;
	localparam apb_addr_t TIMER_MTIMEH_OFS    = 16'h000c;
	localparam apb_addr_t TIMER_MTIMECMP_OFS  = 16'h0010;
	localparam apb_addr_t TIMER_MTIMECMPH_OFS = 16'h0014;

	// UART registers
	localparam apb_addr_t UART_CSR_OFS = 16'h0000;
	localparam apb_addr_t UART_DIV_OFS = 16'h0004;
	localparam apb_addr_t UART_TX_OFS  = 16'h0008;

	localparam uart_div_t UART_DIV_RESET = 16'd16;

endpackage

`default_nettype wire

// ==== periph_subsystem.sv ====
// ----------------------------------------------------------------------
// APB peripheral subsystem
// Host APB port into an address splitter, with a machine timer and a
// UART transmitter behind it
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module periph_subsystem #(
	parameter periph_pkg::apb_addr_t TIMER_BASE = periph_pkg::DEFAULT_TIMER_BASE,
	parameter periph_pkg::apb_addr_t UART_BASE  = periph_pkg::DEFAULT_UART_BASE
) (
	input  wire                   clk,
	input  wire                   rst,

	// Host APB
	input  wire                   psel,
	input  wire                   penable,
	input  wire                   pwrite,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::apb_data_t pwdata,
	output periph_pkg::apb_data_t prdata,
	output logic                  pready,
	output logic                  pslverr,

	// Hart and IO
	input  wire                   dbg_halt,
	output logic                  timer_irq,
	output logic                  uart_irq,
	output logic                  uart_tx
);

	apb_if host_bus ();
	apb_if timer_bus ();
	apb_if uart_bus ();

	// ------------------------------------------------------------------
	// Host port onto the internal bus

	assign host_bus.psel    = psel;
	assign host_bus.penable = penable;
	assign host_bus.pwrite  = pwrite;
	assign host_bus.paddr   = paddr;
	assign host_bus.pwdata  = pwdata;

	assign prdata  = host_bus.prdata;
	assign pready  = host_bus.pready;
	assign pslverr = host_bus.pslverr;

	// ------------------------------------------------------------------
	// Decode and peripherals

	apb_splitter #(
		.TIMER_BASE (TIMER_BASE),
		.UART_BASE  (UART_BASE)
	) u_apb_splitter (
		.host  (host_bus.slave),
		.timer (timer_bus.master),
		.uart  (uart_bus.master)
	);

	riscv_timer u_riscv_timer (
		.clk       (clk),
		.rst       (rst),
		.bus       (timer_bus.slave),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_tx_mini u_uart_tx_mini (
		.clk (clk),
		.rst (rst),
		.bus (uart_bus.slave),
		.tx  (uart_tx),
		.irq (uart_irq)
	);

endmodule

`default_nettype wire

// ==== riscv_timer.sv ====
// ----------------------------------------------------------------------
// RISC-V machine timer
// 64-bit mtime counter and mtimecmp compare register behind 32-bit
// APB word access. Counting pauses while the debugger halts the hart.
// The interrupt is a level, high while mtime >= mtimecmp.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module riscv_timer (
	input  wire  clk,
	input  wire  rst,

	apb_if.slave bus,

	input  wire  dbg_halt,
	output logic timer_irq
);
	import periph_pkg::*;

	logic   ctrl_en;
	mtime_t mtime;
	mtime_t mtimecmp;

	logic   bus_wr;
	logic   reg_hit;

	// Every access completes in its first access cycle
	assign bus.pready = 1'b1;
	assign bus_wr     = bus.psel && bus.penable && bus.pwrite;

	// ------------------------------------------------------------------
	// Register read

	always_comb begin
		reg_hit    = 1'b1;
		bus.prdata = '0;
		case (bus.paddr)
			TIMER_CTRL_OFS:      bus.prdata = {31'd0, ctrl_en};
			TIMER_MTIME_OFS:     bus.prdata = mtime[31:0];
			TIMER_MTIMEH_OFS:    bus.prdata = mtime[63:32];
			TIMER_MTIMECMP_OFS:  bus.prdata = mtimecmp[31:0];
			TIMER_MTIMECMPH_OFS: bus.prdata = mtimecmp[63:32];
			default:             reg_hit    = 1'b0;
		endcase
	end

	assign bus.pslverr = bus.psel && !reg_hit;

	// ------------------------------------------------------------------
	// Control and counter

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_en <= 1'b0;
		end else if (bus_wr && bus.paddr == TIMER_CTRL_OFS) begin
			ctrl_en <= bus.pwdata[0];
		end
	end

	// A word write takes the place of this cycle's increment
	always_ff @(posedge clk) begin
		if (rst) begin
			mtime <= '0;
		end else if (bus_wr && bus.paddr == TIMER_MTIME_OFS) begin
			mtime[31:0] <= bus.pwdata;
		end else if (bus_wr && bus.paddr == TIMER_MTIMEH_OFS) begin
			mtime[63:32] <= bus.pwdata;
		end else if (ctrl_en && !dbg_halt) begin
			mtime <= mtime + 64'd1;
		end
	end

	// Compare value resets to all ones so the interrupt stays quiet
	always_ff @(posedge clk) begin
		if (rst) begin
			mtimecmp <= '1;
		end else if (bus_wr && bus.paddr == TIMER_MTIMECMP_OFS) begin
			mtimecmp[31:0] <= bus.pwdata;
		end else if (bus_wr && bus.paddr == TIMER_MTIMECMPH_OFS) begin
			mtimecmp[63:32] <= bus.pwdata;
		end
	end

	assign timer_irq = mtime >= mtimecmp;

	// ------------------------------------------------------------------
	// Checks

	// The splitter must not leak the enable of another window
	assert property (@(posedge clk) disable iff (rst) bus.penable |-> bus.psel)
		else $error("riscv_timer: penable high without psel");

endmodule

`default_nettype wire

// ==== tb_periph_tasks.svh ====
// ----------------------------------------------------------------------
// Testbench tasks for the APB peripheral subsystem
// APB transfers, model read-back, UART frame capture and compares
// ----------------------------------------------------------------------

`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

	task automatic end_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, expected 0x%08h got 0x%08h", $time, what, exp, got);
			end_with_failure();
		end
	endtask

	task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, expected 0x%02h got 0x%02h", $time, what, exp, got);
			end_with_failure();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, expected %b got %b", $time, what, exp, got);
			end_with_failure();
		end
	endtask

	// Expected read data from the model
	// CSR reads happen only while the UART is idle
	function automatic apb_data_t model_read(input apb_addr_t addr);
		apb_addr_t win;
		apb_addr_t ofs;
		win = addr & WINDOW_MASK;
		ofs = addr & ~WINDOW_MASK;
		if (win == DEFAULT_TIMER_BASE) begin
			case (ofs)
				TIMER_CTRL_OFS:      return {31'd0, m_en};
				TIMER_MTIME_OFS:     return m_mtime[31:0];
				TIMER_MTIMEH_OFS:    return m_mtime[63:32];
				TIMER_MTIMECMP_OFS:  return m_cmp[31:0];
				TIMER_MTIMECMPH_OFS: return m_cmp[63:32];
				default:             return '0;
			endcase
		end else if (win == DEFAULT_UART_BASE) begin
			case (ofs)
				UART_CSR_OFS: return {23'd0, m_irq_en, 8'd0};
				UART_DIV_OFS: return {16'd0, m_div};
				default:      return '0;
			endcase
		end
		return '0;
	endfunction

	function automatic logic is_mapped(input apb_addr_t addr);
		apb_addr_t ofs;
		ofs = addr & ~WINDOW_MASK;
		case (addr & WINDOW_MASK)
			DEFAULT_TIMER_BASE: return ofs inside {TIMER_CTRL_OFS, TIMER_MTIME_OFS,
				TIMER_MTIMEH_OFS, TIMER_MTIMECMP_OFS, TIMER_MTIMECMPH_OFS};
			DEFAULT_UART_BASE:  return ofs inside {UART_CSR_OFS, UART_DIV_OFS, UART_TX_OFS};
			default:            return 1'b0;
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// One APB transfer with the response sampled mid-cycle
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err, output apb_data_t exp_rdata);
		logic done;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		done    = 1'b0;
		while (!done) begin
			@(negedge clk);
			done      = pready;
			rdata     = prdata;
			err       = pslverr;
			exp_rdata = model_read(addr);
			@(posedge clk);
		end
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rdata;
		apb_data_t exp_rdata;
		logic      err;
		apb_xfer(1'b1, addr, data, rdata, err, exp_rdata);
		check_flag(err, 1'b0, $sformatf("pslverr on write to 0x%04h", addr));
	endtask

	task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string what);
		apb_data_t rdata;
		apb_data_t exp_rdata;
		logic      err;
		apb_xfer(1'b0, addr, '0, rdata, err, exp_rdata);
		check_flag(err, 1'b0, what);
		check_data(rdata, exp, what);
	endtask

	task automatic read_check(input apb_addr_t addr, input string what);
		apb_data_t rdata;
		apb_data_t exp_rdata;
		logic      err;
		apb_xfer(1'b0, addr, '0, rdata, err, exp_rdata);
		check_flag(err, !is_mapped(addr), what);
		check_data(rdata, exp_rdata, what);
	endtask

	task automatic random_access();
		apb_addr_t tmr_regs[5] = '{TIMER_CTRL_OFS, TIMER_MTIME_OFS, TIMER_MTIMEH_OFS,
			TIMER_MTIMECMP_OFS, TIMER_MTIMECMPH_OFS};
		int        kind;
		logic      wr;
		logic      err;
		apb_addr_t addr;
		apb_data_t wdata;
		apb_data_t rdata;
		apb_data_t exp_rdata;
		kind  = $urandom_range(0, 6);
		wr    = 1'b0;
		wdata = $urandom();
		case (kind)
			0: addr = tmr_regs[$urandom_range(0, 4)];
			1: begin
				addr = tmr_regs[$urandom_range(0, 4)];
				wr   = 1'b1;
			end
			// Only CSR or DIV since a TX write would start a frame
			2: begin
				addr = DEFAULT_UART_BASE | apb_addr_t'(4 * $urandom_range(0, 1));
				wr   = 1'b1;
			end
			3: addr = DEFAULT_UART_BASE | apb_addr_t'(4 * $urandom_range(0, 2));
			4: begin
				addr = 16'h8000 | apb_addr_t'($urandom() & 32'h3ffc);
				wr   = 1'($urandom_range(0, 1));
			end
			5: addr = DEFAULT_TIMER_BASE | apb_addr_t'($urandom() & 32'h3ffc);
			default: addr = DEFAULT_UART_BASE | apb_addr_t'($urandom() & 32'h3ffc);
		endcase
		apb_xfer(wr, addr, wdata, rdata, err, exp_rdata);
		check_flag(err, !is_mapped(addr), $sformatf("pslverr at 0x%04h", addr));
		check_data(rdata, exp_rdata, $sformatf("prdata at 0x%04h", addr));
	endtask

	// Samples each bit near its middle, starting from the falling start edge
	task automatic capture_frame(input int div, output uart_byte_t data);
		int half;
		half = div / 2 - 1;
		data = '0;
		@(negedge clk);
		while (uart_tx !== 1'b0)
			@(negedge clk);
		repeat (half) @(negedge clk);
		check_flag(uart_tx, 1'b0, "UART start bit");
		check_flag(uart_irq, 1'b0, "uart_irq while busy");
		for (int i = 0; i < 8; i++) begin
			repeat (div) @(negedge clk);
			data[i] = uart_tx;
		end
		repeat (div) @(negedge clk);
		check_flag(uart_tx, 1'b1, "UART stop bit");
		check_flag(uart_irq, 1'b0, "uart_irq while busy");
	endtask

	task automatic wait_idle_irq(input int div);
		repeat (div) @(negedge clk);
		check_flag(uart_irq, m_irq_en, "uart_irq when idle");
		@(posedge clk);
		#1;
		read_check(DEFAULT_UART_BASE | UART_CSR_OFS, "CSR when idle");
	endtask

`endif

// ==== tb_periph_subsystem.sv ====
// ----------------------------------------------------------------------
// Testbench for the APB peripheral subsystem
// Random register traffic, timer interrupt and UART frame checks
// against a model of the timer and UART registers
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsystem;
	import periph_pkg::*;

	// Covers 40 frames at divider 64 and the register traffic with margin
	localparam int TIMEOUT_CYCLES = 60000;

	logic      clk = 1'b0;
	logic      rst;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      dbg_halt;
	logic      timer_irq;
	logic      uart_irq;
	logic      uart_tx;

	// Model state
	logic      m_en;
	mtime_t    m_mtime;
	mtime_t    m_cmp;
	uart_div_t m_div;
	logic      m_irq_en;

	logic      checks_on = 1'b0;
	int        cycle_count = 0;

	apb_addr_t host_win;
	apb_addr_t host_ofs;
	logic      tmr_wr;
	logic      uart_wr;

	periph_subsystem u_periph_subsystem (
		.clk       (clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq),
		.uart_irq  (uart_irq),
		.uart_tx   (uart_tx)
	);

	always #50 clk = ~clk;

	`include "tb_periph_tasks.svh"

	// ------------------------------------------------------------------
	// Register model stepped on every rising edge

	assign host_win = paddr & WINDOW_MASK;
	assign host_ofs = paddr & ~WINDOW_MASK;
	assign tmr_wr   = psel && penable && pwrite && host_win == DEFAULT_TIMER_BASE;
	assign uart_wr  = psel && penable && pwrite && host_win == DEFAULT_UART_BASE;

	always @(posedge clk) begin
		if (rst) begin
			m_en     <= 1'b0;
			m_mtime  <= '0;
			m_cmp    <= '1;
			m_div    <= UART_DIV_RESET;
			m_irq_en <= 1'b0;
		end else begin
			if (tmr_wr && host_ofs == TIMER_CTRL_OFS)
				m_en <= pwdata[0];
			// Writing a word replaces the increment of this cycle
			if (tmr_wr && host_ofs == TIMER_MTIME_OFS)
				m_mtime[31:0] <= pwdata;
			else if (tmr_wr && host_ofs == TIMER_MTIMEH_OFS)
				m_mtime[63:32] <= pwdata;
			else if (m_en && !dbg_halt)
				m_mtime <= m_mtime + 64'd1;
			if (tmr_wr && host_ofs == TIMER_MTIMECMP_OFS)
				m_cmp[31:0] <= pwdata;
			if (tmr_wr && host_ofs == TIMER_MTIMECMPH_OFS)
				m_cmp[63:32] <= pwdata;
			if (uart_wr && host_ofs == UART_CSR_OFS)
				m_irq_en <= pwdata[8];
			if (uart_wr && host_ofs == UART_DIV_OFS)
				m_div <= pwdata[15:0];
		end
	end

	always @(negedge clk) begin
		if (checks_on)
			check_flag(timer_irq, m_mtime >= m_cmp, "timer_irq against mtime >= mtimecmp");
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout reached after %0d cycles", cycle_count);
			end_with_failure();
		end
	end

	// ------------------------------------------------------------------
	// Test sequence

	initial begin
		uart_byte_t sent_a;
		uart_byte_t sent_b;
		uart_byte_t got_a;
		uart_byte_t got_b;
		mtime_t     target;
		int         div;
		int         c0;
		int         cb;

		void'($urandom(35));
		rst      = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		dbg_halt = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst       = 1'b0;
		checks_on = 1'b1;

		@(negedge clk);
		check_flag(uart_tx, 1'b1, "uart_tx after reset");
		check_flag(uart_irq, 1'b0, "uart_irq after reset");
		@(posedge clk);
		#1;
		read_expect(DEFAULT_TIMER_BASE | TIMER_CTRL_OFS, 32'h0, "CTRL after reset");
		read_expect(DEFAULT_TIMER_BASE | TIMER_MTIME_OFS, 32'h0, "mtime after reset");
		read_expect(DEFAULT_UART_BASE | UART_CSR_OFS, 32'h0, "CSR after reset");

		// Counting, halt, word writes and decode errors
		repeat (300) begin
			dbg_halt = 1'($urandom_range(0, 1));
			random_access();
			idle_cycles($urandom_range(0, 2));
		end

		// Compare targets a little ahead of the count
		dbg_halt = 1'b0;
		write_reg(DEFAULT_TIMER_BASE | TIMER_MTIMEH_OFS, 32'h0);
		write_reg(DEFAULT_TIMER_BASE | TIMER_MTIME_OFS, 32'h0);
		write_reg(DEFAULT_TIMER_BASE | TIMER_CTRL_OFS, 32'h1);
		repeat (20) begin
			target = m_mtime + mtime_t'($urandom_range(8, 48));
			write_reg(DEFAULT_TIMER_BASE | TIMER_MTIMECMPH_OFS, target[63:32]);
			write_reg(DEFAULT_TIMER_BASE | TIMER_MTIMECMP_OFS, target[31:0]);
			repeat ($urandom_range(10, 60)) begin
				dbg_halt = 1'($urandom_range(0, 1));
				idle_cycles(1);
			end
		end
		dbg_halt = 1'b0;

		// Single frames
		write_reg(DEFAULT_UART_BASE | UART_CSR_OFS, 32'h100);
		repeat (16) begin
			div    = $urandom_range(4, 64);
			sent_a = uart_byte_t'($urandom_range(0, 255));
			write_reg(DEFAULT_UART_BASE | UART_DIV_OFS, apb_data_t'(div));
			write_reg(DEFAULT_UART_BASE | UART_TX_OFS, apb_data_t'(sent_a));
			capture_frame(div, got_a);
			check_byte(got_a, sent_a, "UART frame");
			wait_idle_irq(div);
		end

		// Second character queued behind a running frame
		repeat (12) begin
			div    = $urandom_range(4, 64);
			sent_a = uart_byte_t'($urandom_range(0, 255));
			sent_b = uart_byte_t'($urandom_range(0, 255));
			write_reg(DEFAULT_UART_BASE | UART_DIV_OFS, apb_data_t'(div));
			write_reg(DEFAULT_UART_BASE | UART_TX_OFS, apb_data_t'(sent_a));
			c0 = cycle_count;
			fork
				begin
					capture_frame(div, got_a);
					capture_frame(div, got_b);
				end
				begin
					write_reg(DEFAULT_UART_BASE | UART_TX_OFS, apb_data_t'(sent_b));
					cb = cycle_count;
				end
			join
			check_byte(got_a, sent_a, "first queued frame");
			check_byte(got_b, sent_b, "second queued frame");
			check_flag(cb - c0 > 10 * div, 1'b1, "held TX write done after stop bit");
			wait_idle_irq(div);
		end

		idle_cycles(2);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_tx_mini.sv ====
// ----------------------------------------------------------------------
// UART transmitter
// Sends 8N1 frames, LSB first, with a programmable number of clock
// cycles per bit. A TX write while a frame is in flight is held off
// with pready low. The interrupt is high while enabled and idle.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module uart_tx_mini (
	input  wire  clk,
	input  wire  rst,

	apb_if.slave bus,

	output logic tx,
	output logic irq
);
	import periph_pkg::*;

	uart_state_t state;
	uart_div_t   div;
	uart_div_t   div_cnt;
	uart_div_t   div_last;
	logic [2:0]  bit_cnt;
	uart_byte_t  shift;
	logic        irq_en;

	logic        busy;
	logic        bit_end;
	logic        bus_wr;
	logic        tx_wr;
	logic        tx_fire;
	logic        reg_hit;

	assign busy     = state != UART_IDLE;
	assign div_last = div - 16'd1;
	assign bit_end  = div_cnt >= div_last;

	// ------------------------------------------------------------------
	// APB side

	assign bus_wr  = bus.psel && bus.penable && bus.pwrite;
	assign tx_wr   = bus.psel && bus.pwrite && bus.paddr == UART_TX_OFS;
	assign tx_fire = bus_wr && bus.paddr == UART_TX_OFS && !busy;

	// Stall a character write until the engine is free
	assign bus.pready = !(tx_wr && busy);

	always_comb begin
		reg_hit    = 1'b1;
		bus.prdata = '0;
		case (bus.paddr)
			UART_CSR_OFS: bus.prdata = {23'd0, irq_en, 7'd0, busy};
			UART_DIV_OFS: bus.prdata = {16'd0, div};
			UART_TX_OFS:  bus.prdata = '0;
			default:      reg_hit    = 1'b0;
		endcase
	end

	assign bus.pslverr = bus.psel && !reg_hit;

	always_ff @(posedge clk) begin
		if (rst) begin
			irq_en <= 1'b0;
			div    <= UART_DIV_RESET;
		end else if (bus_wr) begin
			if (bus.paddr == UART_CSR_OFS)
				irq_en <= bus.pwdata[8];
			if (bus.paddr == UART_DIV_OFS)
				div <= bus.pwdata[15:0];
		end
	end

	// ------------------------------------------------------------------
	// Transmit engine

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= UART_IDLE;
			tx      <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			div_cnt <= bit_end ? '0 : div_cnt + 16'd1;
			case (state)
				UART_IDLE: begin
					div_cnt <= '0;
					bit_cnt <= '0;
					if (tx_fire) begin
						state <= UART_START;
						tx    <= 1'b0;
					end
				end
				UART_START: if (bit_end) begin
					state <= UART_DATA;
					tx    <= shift[0];
				end
				UART_DATA: if (bit_end) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						state <= UART_STOP;
						tx    <= 1'b1;
					end else begin
						tx <= shift[1];
					end
				end
				default: if (bit_end) begin
					state <= UART_IDLE;
				end
			endcase
		end
	end

	// Character shifter, loaded on the accepted write
	always_ff @(posedge clk) begin
		if (tx_fire)
			shift <= bus.pwdata[7:0];
		else if (state == UART_DATA && bit_end)
			shift <= shift >> 1;
	end

	assign irq = irq_en && !busy;

	// The line must rest at mark level between frames
	assert property (@(posedge clk) disable iff (rst) state == UART_IDLE |-> tx)
		else $error("uart_tx_mini: tx low while idle");

endmodule

`default_nettype wire
